// ==== verilog.f ====
memPkg.sv
memRequestArbiter.sv
memByteSequencer.sv
memWordAssembler.sv
memCtrl.sv
tb_memCtrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_memCtrl
FILELIST ?= verilog.f
OBJDIR ?= obj_dir
PASS_MSG ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== tb_memCtrl.sv ====
module tb_memCtrl;

    localparam int AddrWidth = 32;
    localparam int TimeoutCycles = 50;
    localparam int NumRows = 13;

    typedef enum logic [1:0] {
        KIND_FETCH,
        KIND_LOAD,
        KIND_STORE,
        KIND_BOTH
    } kind_e;

    typedef enum logic [1:0] {
        STALL_NONE,
        STALL_RDY,
        STALL_IOFULL
    } stall_e;

    typedef struct packed {
        kind_e kind;
        logic [7:0] addr;
        memPkg::len_t len;
        memPkg::word_t wdata;
        stall_e stall;
    } row_t;

    logic clk;
    logic rst;
    logic i_rdy;
    logic i_ioBufferFull;
    memPkg::byte_t i_memRdata = '0;
    logic [AddrWidth-1:0] o_memAddr;
    logic o_memWe;
    memPkg::byte_t o_memWdata;
    memPkg::owner_t o_owner;
    logic i_fetchEn;
    logic [AddrWidth-1:0] i_fetchAddr;
    logic o_fetchDone;
    memPkg::word_t o_inst;
    logic i_dataEn;
    logic i_dataStore;
    memPkg::len_t i_dataLen;
    logic [AddrWidth-1:0] i_dataAddr;
    memPkg::word_t i_dataWdata;
    logic o_dataDone;
    memPkg::word_t o_dataRdata;

    memPkg::byte_t ram [256];
    memPkg::byte_t shadow [256];
    row_t rows [NumRows];
    int rowErrors;
    int stallWrites = 0;
    int passCount;
    int failCount;
    logic timedOut;

    memCtrl #(
        .AddrWidth(AddrWidth)
    ) u_dut (
        .*
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // RAM with one cycle read latency, its read register shares the controller stall
    always @(posedge clk) begin
        if (o_memWe) begin
            ram[o_memAddr[7:0]] <= o_memWdata;
        end
        if (i_rdy && !i_ioBufferFull) begin
            i_memRdata <= ram[o_memAddr[7:0]];
        end
    end

    always @(negedge clk) begin
        if (!rst && o_memWe && !(i_rdy && !i_ioBufferFull)) begin
            $display("RAM write issued while stalled at time %0t", $time);
            stallWrites++;
        end
    end

    task automatic checkWord(input string name, input memPkg::word_t got,
                             input memPkg::word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            rowErrors++;
        end
    endtask

    task automatic checkOwner(input string name, input memPkg::owner_t got,
                              input memPkg::owner_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            rowErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            rowErrors++;
        end
    endtask

    task automatic checkLatency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            rowErrors++;
        end
    endtask

    // little-endian word from the shadow, upper bytes zero
    function automatic memPkg::word_t expectedWord(input logic [7:0] addr,
                                                   input memPkg::len_t len);
        memPkg::word_t w;
        int i;
        w = '0;
        for (i = 0; i < int'(len); i++) begin
            w = w | (memPkg::word_t'(shadow[addr + 8'(i)]) << (8 * i));
        end
        return w;
    endfunction

    task automatic applyStall(input stall_e stall);
        logic hold;
        hold = (stall != STALL_NONE) && ($urandom_range(2, 0) == 0);
        i_rdy = !(hold && (stall == STALL_RDY));
        i_ioBufferFull = hold && (stall == STALL_IOFULL);
    endtask

    // counts advancing edges from the first one until the chosen done shows
    task automatic waitForDone(input logic wantFetch, input memPkg::owner_t expOwner,
                               input stall_e stall, output int advEdges, output logic ok);
        int cycles;
        logic advancing;
        advEdges = 0;
        ok = 1'b0;
        for (cycles = 0; cycles < TimeoutCycles && !ok; cycles++) begin
            applyStall(stall);
            advancing = i_rdy && !i_ioBufferFull;
            @(posedge clk);
            #1;
            if (advancing) begin
                advEdges++;
            end
            checkOwner("o_owner", o_owner, (advEdges > 0) ? expOwner : memPkg::OWNER_NONE);
            if (wantFetch ? o_dataDone : o_fetchDone) begin
                $display("a done pulse came from the wrong requester");
                rowErrors++;
            end
            ok = wantFetch ? o_fetchDone : o_dataDone;
        end
        if (!ok) begin
            $display("timeout: no done pulse within %0d cycles", TimeoutCycles);
        end
        i_rdy = 1'b1;
        i_ioBufferFull = 1'b0;
    endtask

    task automatic reportTest(input string label);
        if (rowErrors == 0) begin
            passCount++;
            $display("%s: passed", label);
        end else begin
            failCount++;
            $display("%s: failed with %0d errors", label, rowErrors);
        end
    endtask

    task automatic runRow(input int idx, input row_t row);
        logic [7:0] fetchAddr;
        int advEdges;
        int i;
        logic ok;
        kind_e kind;
        memPkg::word_t expData;
        memPkg::word_t expInst;
        rowErrors = 0;
        ok = 1'b1;
        kind = row.kind;
        // in a dual request the fetch reads eight bytes further on
        fetchAddr = (kind == KIND_BOTH) ? row.addr + 8'h08 : row.addr;
        expData = expectedWord(row.addr, row.len);
        expInst = expectedWord(fetchAddr, memPkg::FETCH_LEN);
        i_dataAddr = AddrWidth'(row.addr);
        i_fetchAddr = AddrWidth'(fetchAddr);
        i_dataLen = row.len;
        i_dataWdata = row.wdata;
        i_dataStore = (kind == KIND_STORE);
        i_dataEn = (kind != KIND_FETCH);
        i_fetchEn = (kind == KIND_FETCH) || (kind == KIND_BOTH);
        if (i_dataEn) begin
            waitForDone(1'b0, memPkg::OWNER_DATA, row.stall, advEdges, ok);
            if (ok) begin
                checkLatency("data latency", advEdges, int'(row.len) + (i_dataStore ? 1 : 2));
                if (i_dataStore) begin
                    for (i = 0; i < int'(row.len); i++) begin
                        shadow[row.addr + 8'(i)] = 8'(row.wdata >> (8 * i));
                    end
                end else begin
                    checkWord("o_dataRdata", o_dataRdata, expData);
                end
                @(posedge clk);
                #1;
                i_dataEn = 1'b0;
            end
        end
        if (i_fetchEn && ok) begin
            waitForDone(1'b1, memPkg::OWNER_FETCH, row.stall, advEdges, ok);
            if (ok) begin
                checkLatency("fetch latency", advEdges, int'(memPkg::FETCH_LEN) + 2);
                checkWord("o_inst", o_inst, expInst);
                @(posedge clk);
                #1;
                i_fetchEn = 1'b0;
            end
        end
        if (ok) begin
            checkOwner("o_owner", o_owner, memPkg::OWNER_NONE);
            checkFlag("o_fetchDone", o_fetchDone, 1'b0);
            checkFlag("o_dataDone", o_dataDone, 1'b0);
        end else begin
            rowErrors++;
            timedOut = 1'b1;
        end
        reportTest($sformatf("row %0d %s at 0x%02h", idx, kind.name(), row.addr));
    endtask

    initial begin
        memPkg::byte_t fill;
        int a;
        void'($urandom(51024));
        rst = 1'b1;
        i_rdy = 1'b1;
        i_ioBufferFull = 1'b0;
        i_fetchEn = 1'b0;
        i_fetchAddr = '0;
        i_dataEn = 1'b0;
        i_dataStore = 1'b0;
        i_dataLen = 3'd1;
        i_dataAddr = '0;
        i_dataWdata = '0;
        passCount = 0;
        failCount = 0;
        timedOut = 1'b0;
        for (a = 0; a < 256; a++) begin
            fill = 8'($urandom);
            ram[a] <= fill;
            shadow[a] = fill;
        end
        rows[0] = '{KIND_FETCH, 8'h20, 3'd4, 32'h0, STALL_NONE};
        rows[1] = '{KIND_LOAD, 8'h31, 3'd1, 32'h0, STALL_NONE};
        rows[2] = '{KIND_LOAD, 8'h42, 3'd2, 32'h0, STALL_NONE};
        rows[3] = '{KIND_LOAD, 8'h50, 3'd4, 32'h0, STALL_NONE};
        rows[4] = '{KIND_STORE, 8'h61, 3'd1, 32'h0000_00a5, STALL_NONE};
        rows[5] = '{KIND_LOAD, 8'h60, 3'd4, 32'h0, STALL_NONE};
        rows[6] = '{KIND_STORE, 8'h72, 3'd2, 32'h0000_beef, STALL_RDY};
        rows[7] = '{KIND_STORE, 8'h80, 3'd4, 32'h1234_5678, STALL_IOFULL};
        rows[8] = '{KIND_LOAD, 8'h70, 3'd4, 32'h0, STALL_RDY};
        rows[9] = '{KIND_LOAD, 8'h80, 3'd4, 32'h0, STALL_IOFULL};
        rows[10] = '{KIND_FETCH, 8'h90, 3'd4, 32'h0, STALL_RDY};
        rows[11] = '{KIND_BOTH, 8'ha0, 3'd2, 32'h0, STALL_NONE};
        rows[12] = '{KIND_BOTH, 8'hb0, 3'd1, 32'h0, STALL_IOFULL};
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        rowErrors = 0;
        checkOwner("o_owner", o_owner, memPkg::OWNER_NONE);
        checkFlag("o_fetchDone", o_fetchDone, 1'b0);
        checkFlag("o_dataDone", o_dataDone, 1'b0);
        checkFlag("o_memWe", o_memWe, 1'b0);
        reportTest("reset state");
        for (a = 0; a < NumRows && !timedOut; a++) begin
            runRow(a, rows[a]);
        end
        $display("%0d tests passed, %0d failed, %0d stalled writes",
                 passCount, failCount, stallWrites);
        if (failCount == 0 && stallWrites == 0 && !timedOut) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== memCtrl.sv ====
module memCtrl #(
    parameter int AddrWidth = memPkg::ADDR_W
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_rdy,
    input  logic                 i_ioBufferFull,
    input  memPkg::byte_t        i_memRdata,
    output logic [AddrWidth-1:0] o_memAddr,
    output logic                 o_memWe,
    output memPkg::byte_t        o_memWdata,
    output memPkg::owner_t       o_owner,
    input  logic                 i_fetchEn,
    input  logic [AddrWidth-1:0] i_fetchAddr,
    output logic                 o_fetchDone,
    output memPkg::word_t        o_inst,
    input  logic                 i_dataEn,
    input  logic                 i_dataStore,
    input  memPkg::len_t         i_dataLen,
    input  logic [AddrWidth-1:0] i_dataAddr,
    input  memPkg::word_t        i_dataWdata,
    output logic                 o_dataDone,
    output memPkg::word_t        o_dataRdata
);
    logic advance;
    logic start;
    logic [AddrWidth-1:0] baseAddr;
    memPkg::len_t len;
    logic store;
    memPkg::word_t wdata;
    logic seqFinish;
    logic byteValid;
    logic [1:0] byteLane;
    logic lastByte;

    // global ready and a full I/O buffer both freeze everything
    assign advance = i_rdy && !i_ioBufferFull;

    memRequestArbiter #(
        .AddrWidth(AddrWidth)
    ) u_arbiter (
        .clk(clk),
        .rst(rst),
        .i_advance(advance),
        .i_fetchEn(i_fetchEn),
        .i_fetchAddr(i_fetchAddr),
        .i_dataEn(i_dataEn),
        .i_dataStore(i_dataStore),
        .i_dataLen(i_dataLen),
        .i_dataAddr(i_dataAddr),
        .i_dataWdata(i_dataWdata),
        .i_seqFinish(seqFinish),
        .o_start(start),
        .o_baseAddr(baseAddr),
        .o_len(len),
        .o_store(store),
        .o_wdata(wdata),
        .o_owner(o_owner)
    );

    memByteSequencer #(
        .AddrWidth(AddrWidth)
    ) u_sequencer (
        .clk(clk),
        .rst(rst),
        .i_advance(advance),
        .i_start(start),
        .i_baseAddr(baseAddr),
        .i_len(len),
        .i_store(store),
        .i_wdata(wdata),
        .o_memAddr(o_memAddr),
        .o_memWe(o_memWe),
        .o_memWdata(o_memWdata),
        .o_byteValid(byteValid),
        .o_byteLane(byteLane),
        .o_lastByte(lastByte),
        .o_finish(seqFinish)
    );

    memWordAssembler #(
        .AddrWidth(AddrWidth)
    ) u_assembler (
        .clk(clk),
        .rst(rst),
        .i_advance(advance),
        .i_memRdata(i_memRdata),
        .i_byteValid(byteValid),
        .i_byteLane(byteLane),
        .i_lastByte(lastByte),
        .i_finish(seqFinish),
        .i_owner(o_owner),
        .o_fetchDone(o_fetchDone),
        .o_inst(o_inst),
        .o_dataDone(o_dataDone),
        .o_dataRdata(o_dataRdata)
    );

endmodule

// ==== memWordAssembler.sv ====
module memWordAssembler #(
    parameter int AddrWidth = memPkg::ADDR_W
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           i_advance,
    input  memPkg::byte_t  i_memRdata,
    input  logic           i_byteValid,
    input  logic [1:0]     i_byteLane,
    input  logic           i_lastByte,
    input  logic           i_finish,
    input  memPkg::owner_t i_owner,
    output logic           o_fetchDone,
    output memPkg::word_t  o_inst,
    output logic           o_dataDone,
    output memPkg::word_t  o_dataRdata
);
    memPkg::word_t gathered;
    memPkg::word_t merged;
    memPkg::word_t finalWord;

    // address path lives elsewhere, but the narrowest supported width is checked here
    if (AddrWidth < 8) begin : gen_widthCheck
        $error("memWordAssembler: AddrWidth %0d below 8", AddrWidth);
    end

    // lane 0 opens a new transfer, so upper bytes start at zero
    always_comb begin
        merged = (i_byteLane == 2'd0) ? '0 : gathered;
        merged[{i_byteLane, 3'b000} +: 8] = i_memRdata;
    end

    // final byte arrives in the finish cycle, take it straight from the bus
    assign finalWord = (i_byteValid && i_lastByte) ? merged : gathered;

    always_ff @(posedge clk) begin
        if (i_advance && i_byteValid) begin
            gathered <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance && i_finish) begin
            if (i_owner == memPkg::OWNER_FETCH) begin
                o_inst <= finalWord;
            end else begin
                o_dataRdata <= finalWord;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_fetchDone <= 1'b0;
            o_dataDone <= 1'b0;
        end else if (i_advance) begin
            o_fetchDone <= i_finish && (i_owner == memPkg::OWNER_FETCH);
            o_dataDone <= i_finish && (i_owner == memPkg::OWNER_DATA);
        end
    end

    doneExclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(o_fetchDone && o_dataDone)
    ) else $error("fetch and data done raised together");

endmodule

// ==== memByteSequencer.sv ====
module memByteSequencer #(
    parameter int AddrWidth = memPkg::ADDR_W
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_advance,
    input  logic                 i_start,
    input  logic [AddrWidth-1:0] i_baseAddr,
    input  memPkg::len_t         i_len,
    input  logic                 i_store,
    input  memPkg::word_t        i_wdata,
    output logic [AddrWidth-1:0] o_memAddr,
    output logic                 o_memWe,
    output memPkg::byte_t        o_memWdata,
    output logic                 o_byteValid,
    output logic [1:0]           o_byteLane,
    output logic                 o_lastByte,
    output logic                 o_finish
);
    memPkg::seqState_e state;
    memPkg::len_t offset;
    logic issuing;
    logic lastOffset;

    assign issuing = (state == memPkg::SEQ_ISSUE);
    assign lastOffset = (offset == i_len - 3'd1);

    // one byte per cycle in little-endian order from the base address
    assign o_memAddr = i_baseAddr + AddrWidth'(offset);
    assign o_memWdata = i_wdata[{offset[1:0], 3'b000} +: 8];

    // no write may escape while stalled
    assign o_memWe = issuing && i_store && i_advance;

    // stores end on the last write and reads after the drain cycle
    assign o_finish = (issuing && i_store && lastOffset) || (state == memPkg::SEQ_DRAIN);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::SEQ_IDLE;
            offset <= '0;
        end else if (i_advance) begin
            case (state)
                memPkg::SEQ_IDLE: begin
                    if (i_start) begin
                        state <= memPkg::SEQ_ISSUE;
                        offset <= '0;
                    end
                end
                memPkg::SEQ_ISSUE: begin
                    if (lastOffset) begin
                        state <= i_store ? memPkg::SEQ_IDLE : memPkg::SEQ_DRAIN;
                    end else begin
                        offset <= offset + 3'd1;
                    end
                end
                memPkg::SEQ_DRAIN: begin
                    // last read byte is on the bus now
                    state <= memPkg::SEQ_IDLE;
                end
                default: begin
                    state <= memPkg::SEQ_IDLE;
                end
            endcase
        end
    end

    // strobes trail the read address by one cycle to match RAM latency
    always_ff @(posedge clk) begin
        if (rst) begin
            o_byteValid <= 1'b0;
            o_lastByte <= 1'b0;
            o_byteLane <= '0;
        end else if (i_advance) begin
            o_byteValid <= issuing && !i_store;
            o_lastByte <= issuing && !i_store && lastOffset;
            o_byteLane <= offset[1:0];
        end
    end

    weOnlyInIssue: assert property (
        @(posedge clk) disable iff (rst)
        o_memWe |-> (issuing && !o_byteValid)
    ) else $error("RAM write outside ISSUE or during a read return");

endmodule

// ==== memRequestArbiter.sv ====
module memRequestArbiter #(
    parameter int AddrWidth = memPkg::ADDR_W
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_advance,
    input  logic                 i_fetchEn,
    input  logic [AddrWidth-1:0] i_fetchAddr,
    input  logic                 i_dataEn,
    input  logic                 i_dataStore,
    input  memPkg::len_t         i_dataLen,
    input  logic [AddrWidth-1:0] i_dataAddr,
    input  memPkg::word_t        i_dataWdata,
    input  logic                 i_seqFinish,
    output logic                 o_start,
    output logic [AddrWidth-1:0] o_baseAddr,
    output memPkg::len_t         o_len,
    output logic                 o_store,
    output memPkg::word_t        o_wdata,
    output memPkg::owner_t       o_owner
);
    logic idle;
    logic releasePend;

    assign idle = (o_owner == memPkg::OWNER_NONE);

    // accept on an advancing edge while nobody owns the RAM
    assign o_start = idle && i_advance && (i_dataEn || i_fetchEn);

    // owner is held one cycle past finish, through the done pulse,
    // so the requester can drop its enable before we look again
    always_ff @(posedge clk) begin
        if (rst) begin
            o_owner <= memPkg::OWNER_NONE;
            releasePend <= 1'b0;
        end else if (i_advance) begin
            if (o_start) begin
                o_owner <= i_dataEn ? memPkg::OWNER_DATA : memPkg::OWNER_FETCH;
            end else if (releasePend) begin
                o_owner <= memPkg::OWNER_NONE;
                releasePend <= 1'b0;
            end else if (i_seqFinish) begin
                releasePend <= 1'b1;
            end
        end
    end

    // data port has priority over fetch
    always_ff @(posedge clk) begin
        if (o_start) begin
            o_baseAddr <= i_dataEn ? i_dataAddr : i_fetchAddr;
            o_len <= i_dataEn ? i_dataLen : memPkg::FETCH_LEN;
            o_store <= i_dataEn && i_dataStore;
            o_wdata <= i_dataWdata;
        end
    end

    dataLenLegal: assert property (
        @(posedge clk) disable iff (rst)
        (o_start && i_dataEn) |-> (i_dataLen inside {3'd1, 3'd2, 3'd4})
    ) else $error("illegal data length %0d accepted", i_dataLen);

    finishOnlyWhenOwned: assert property (
        @(posedge clk) disable iff (rst)
        i_seqFinish |-> !idle
    ) else $error("sequencer finished with no owner");

endmodule

// ==== memPkg.sv ====
package memPkg;

    // default address width, overridden from the top level
    localparam int ADDR_W = 32;

    typedef logic [31:0] word_t;
    typedef logic [7:0] byte_t;

    // byte count of one transfer, only 1, 2 and 4 are legal
    typedef logic [2:0] len_t;

    localparam len_t FETCH_LEN = 3'd4;

    // which requester holds the RAM
    typedef logic [1:0] owner_t;

    localparam owner_t OWNER_NONE = 2'd0;
    localparam owner_t OWNER_DATA = 2'd1;
    localparam owner_t OWNER_FETCH = 2'd2;

    // byte sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_DRAIN
    } seqState_e;

endpackage
